//--- common/dma_cfg_pkg.sv
`default_nettype none

package dma_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Data path geometry
  ////////////////////////////////////////////////////////////

  // One memory word and its byte enables
  localparam int data_w    = 64;
  localparam int strb_w    = 8;
  // Low address bits that pick a byte inside a word
  localparam int mask_bits = 3;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  localparam int addr_w         = 16;
  // Every slot spans 256 bytes, so the slot number sits above bit 8
  localparam int lead_zero_bits = 8;
  localparam int slot_w         = 8;
  localparam int port_w         = 2;
  localparam int len_w          = 16;
  // Packets start two bytes into their slot
  localparam int slot_start_offset = 2;

  typedef logic [data_w-1:0] data_t;
  typedef logic [strb_w-1:0] strb_t;
  typedef logic [addr_w-1:0] addr_t;
  // Holds a byte shift from 0 up to a full word of 8
  typedef logic [mask_bits:0] shift_t;

endpackage

`default_nettype wire

//--- common/dma_desc_pkg.sv
`default_nettype none

package dma_desc_pkg;

  ////////////////////////////////////////////////////////////
  // Receive descriptor fields
  ////////////////////////////////////////////////////////////

  typedef logic [dma_cfg_pkg::slot_w-1:0] slot_t;
  typedef logic [dma_cfg_pkg::port_w-1:0] port_t;
  typedef logic [dma_cfg_pkg::len_w-1:0]  len_t;

  // The port travels zero-extended in a full byte of the descriptor
  localparam int desc_port_w = 8;
  // Top bits of the descriptor are reserved and always zero
  localparam int desc_rsvd_w = 16;

  // Layout from bit 63 down to bit 0
  // Reserved, base address, port, slot and then the byte length
  typedef struct packed {
    logic [desc_rsvd_w-1:0] rsvd;
    dma_cfg_pkg::addr_t     base_addr;
    logic [desc_port_w-1:0] port;
    slot_t                  slot;
    len_t                   len;
  } recv_desc_t;

  // Number of finished descriptors that can wait for software
  localparam int recv_desc_depth = 8;

endpackage

`default_nettype wire

//--- common/rx_beat_if.sv
`timescale 1ns/1ns
`default_nettype none

// Carries the stage-1 beat from the capture stage into the realigner
interface rx_beat_if;

  import dma_cfg_pkg::*;

  // Beat contents and packet metadata, owned by capture
  data_t  data;
  strb_t  strb;
  logic   last;
  logic   spill;
  logic   first;
  logic   take;
  shift_t shift;
  addr_t  start_addr;

  // Memory progress, owned by the realigner
  logic   advance;
  logic   flush;
  logic   ready;

  modport capture (
    output data, strb, last, spill, first, take, shift, start_addr,
    input  advance, flush, ready
  );

  modport realign (
    input  data, strb, last, spill, first, take, shift, start_addr,
    output advance, flush, ready
  );

endinterface

`default_nettype wire

//--- sim/tb_axis_rx_dma.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axis_rx_dma;

  import dma_cfg_pkg::*;
  import dma_desc_pkg::*;

  localparam int num_pkts       = 200;
  localparam int max_len        = 40;
  localparam int max_pending    = 4;
  localparam int slot_bytes     = 256;
  localparam int pkt_offset     = 2;
  localparam int timeout_cycles = num_pkts * 12 + 500;

  logic       clk;
  logic       rst;
  data_t      s_axis_tdata;
  strb_t      s_axis_tkeep;
  logic       s_axis_tvalid;
  logic       s_axis_tready;
  logic       s_axis_tlast;
  slot_t      s_axis_tdest;
  port_t      s_axis_tuser;
  logic       mem_wr_en;
  strb_t      mem_wr_strb;
  addr_t      mem_wr_addr;
  data_t      mem_wr_data;
  logic       mem_wr_last;
  logic       mem_wr_ready;
  logic       recv_desc_valid;
  logic       recv_desc_ready;
  recv_desc_t recv_desc;

  integer     seed;
  int         cycles;
  // Packets handed to the driver, and descriptors taken by the monitor
  int         pkts_sent;
  int         desc_taken;
  // Packet the memory writes belong to, and the word index inside it
  int         wr_pkt;
  int         wr_idx;
  logic       stall_prev;
  addr_t      held_addr;
  logic       desc_hold_prev;
  recv_desc_t held_desc;

  slot_t      exp_slot [num_pkts];
  port_t      exp_port [num_pkts];
  len_t       exp_len [num_pkts];
  logic [7:0] pkt_bytes [num_pkts][max_len];
  // Byte memory model of the whole packet memory
  logic [7:0] mem_model [1 << addr_w];
  logic       written [max_len];
  recv_desc_t exp_desc_q [$];

  axis_rx_dma u_axis_rx_dma (
    .clk             (clk),
    .rst             (rst),
    .s_axis_tdata    (s_axis_tdata),
    .s_axis_tkeep    (s_axis_tkeep),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .s_axis_tlast    (s_axis_tlast),
    .s_axis_tdest    (s_axis_tdest),
    .s_axis_tuser    (s_axis_tuser),
    .mem_wr_en       (mem_wr_en),
    .mem_wr_strb     (mem_wr_strb),
    .mem_wr_addr     (mem_wr_addr),
    .mem_wr_data     (mem_wr_data),
    .mem_wr_last     (mem_wr_last),
    .mem_wr_ready    (mem_wr_ready),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_ready (recv_desc_ready),
    .recv_desc       (recv_desc)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) report_failure($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) report_failure($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_desc(input string name, input recv_desc_t got, input recv_desc_t exp);
    if (got !== exp) report_failure($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_failure($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  function automatic int unsigned rand_below(input int unsigned n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  task automatic clear_written();
    for (int k = 0; k < max_len; k++) begin
      written[k] = 1'b0;
    end
  endtask

  // Every input change happens here on the falling edge where the ready lines are re-rolled
  task automatic next_cycle();
    @(negedge clk);
    mem_wr_ready    = (rand_below(4) != 0);
    recv_desc_ready = (rand_below(2) != 0);
  endtask

  // Random packet plus the descriptor it must produce
  task automatic make_packet(input int p);
    recv_desc_t d;
    exp_len[p]  = len_t'(rand_below(max_len) + 1);
    exp_slot[p] = slot_t'(rand_below(256));
    exp_port[p] = port_t'(rand_below(4));
    for (int k = 0; k < max_len; k++) begin
      pkt_bytes[p][k] = 8'(rand_below(256));
    end
    d           = '0;
    d.base_addr = addr_t'(int'(exp_slot[p]) * slot_bytes + pkt_offset);
    d.port      = 8'(exp_port[p]);
    d.slot      = exp_slot[p];
    d.len       = exp_len[p];
    exp_desc_q.push_back(d);
  endtask

  task automatic send_packet(input int p);
    int    nbeats;
    int    idx;
    logic  accepted;
    data_t word;
    strb_t keep;
    nbeats = (int'(exp_len[p]) + strb_w - 1) / strb_w;
    for (int b = 0; b < nbeats; b++) begin
      word = '0;
      keep = '0;
      // Kept bytes fill the low lanes and unused lanes carry junk
      for (int i = 0; i < strb_w; i++) begin
        idx = b * strb_w + i;
        if (idx < int'(exp_len[p])) begin
          word[i*8 +: 8] = pkt_bytes[p][idx];
          keep[i]        = 1'b1;
        end else begin
          word[i*8 +: 8] = 8'(rand_below(256));
        end
      end
      s_axis_tvalid = 1'b1;
      s_axis_tdata  = word;
      s_axis_tkeep  = keep;
      s_axis_tlast  = (b == nbeats - 1);
      s_axis_tdest  = exp_slot[p];
      s_axis_tuser  = exp_port[p];
      accepted      = 1'b0;
      while (!accepted) begin
        @(posedge clk);
        accepted = s_axis_tready;
        next_cycle();
      end
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
  endtask

  initial begin
    seed            = 54;
    clk             = 1'b0;
    rst             = 1'b1;
    s_axis_tdata    = '0;
    s_axis_tkeep    = '0;
    s_axis_tvalid   = 1'b0;
    s_axis_tlast    = 1'b0;
    s_axis_tdest    = '0;
    s_axis_tuser    = '0;
    mem_wr_ready    = 1'b0;
    recv_desc_ready = 1'b0;
    pkts_sent       = 0;
    desc_taken      = 0;
    wr_pkt          = 0;
    wr_idx          = 0;
    cycles          = 0;
    clear_written();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int p = 0; p < num_pkts; p++) begin
      // Keep the descriptor FIFO well below its depth
      while (pkts_sent - desc_taken >= max_pending) next_cycle();
      make_packet(p);
      pkts_sent++;
      send_packet(p);
      if (rand_below(4) == 0) next_cycle();
    end
    while (desc_taken < num_pkts) next_cycle();
    // A few quiet cycles so a stray write would still be caught
    repeat (4) next_cycle();
    if (wr_pkt != num_pkts || exp_desc_q.size() != 0) begin
      report_failure("Packets or descriptors are missing at the end of the run");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory and descriptor monitors
  ////////////////////////////////////////////////////////////

  // At the closing write of a packet every payload byte must sit in memory
  task automatic finish_packet(input addr_t base);
    for (int k = 0; k < int'(exp_len[wr_pkt]); k++) begin
      if (!written[k]) begin
        report_failure($sformatf("Byte %0d of packet %0d was never written", k, wr_pkt));
      end
      check_byte("memory byte", mem_model[int'(base) + pkt_offset + k], pkt_bytes[wr_pkt][k]);
    end
    wr_pkt++;
    wr_idx = 0;
    clear_written();
  endtask

  task automatic take_write();
    addr_t base;
    int    nwords;
    int    k;
    if (wr_pkt >= pkts_sent) begin
      report_failure("Memory write seen while no packet was in flight");
    end else begin
      base   = addr_t'(int'(exp_slot[wr_pkt]) * slot_bytes);
      // Payload spans offsets 2 to len+1 and takes one write per word it touches
      nwords = (int'(exp_len[wr_pkt]) + pkt_offset - 1) / strb_w + 1;
      // Word-aligned address stepping up by one word per write
      check_addr("mem_wr_addr", mem_wr_addr, addr_t'(int'(base) + wr_idx * strb_w));
      for (int l = 0; l < strb_w; l++) begin
        if (mem_wr_strb[l]) begin
          k = int'(mem_wr_addr) + l - int'(base) - pkt_offset;
          if (k < 0 || k >= int'(exp_len[wr_pkt])) begin
            report_failure($sformatf("Lane %0d enabled outside packet %0d at 0x%h",
                                     l, wr_pkt, mem_wr_addr));
          end else begin
            // A byte written again must keep the value it already holds
            if (written[k]) begin
              check_byte($sformatf("mem_wr_data lane %0d", l), mem_wr_data[l*8 +: 8],
                         mem_model[int'(mem_wr_addr) + l]);
            end
            mem_model[int'(mem_wr_addr) + l] = mem_wr_data[l*8 +: 8];
            written[k] = 1'b1;
          end
        end
      end
      check_flag("mem_wr_last", mem_wr_last, wr_idx == nwords - 1);
      if (mem_wr_last) begin
        finish_packet(base);
      end else begin
        wr_idx++;
      end
    end
  endtask

  task automatic take_desc();
    recv_desc_t exp;
    if (exp_desc_q.size() == 0) begin
      report_failure("Descriptor appeared with no packet outstanding");
    end else begin
      exp = exp_desc_q.pop_front();
      check_desc("recv_desc", recv_desc, exp);
      desc_taken++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      stall_prev     = 1'b0;
      desc_hold_prev = 1'b0;
    end else begin
      // A stalled write must still be offered at the same address
      if (stall_prev) begin
        check_flag("mem_wr_en", mem_wr_en, 1'b1);
        check_addr("mem_wr_addr", mem_wr_addr, held_addr);
      end
      stall_prev = mem_wr_en && !mem_wr_ready;
      held_addr  = mem_wr_addr;
      if (mem_wr_en && mem_wr_ready) take_write();
      // An offered descriptor holds until it is taken
      if (desc_hold_prev) begin
        check_flag("recv_desc_valid", recv_desc_valid, 1'b1);
        check_desc("recv_desc", recv_desc, held_desc);
      end
      desc_hold_prev = recv_desc_valid && !recv_desc_ready;
      held_desc      = recv_desc;
      if (recv_desc_valid && recv_desc_ready) take_desc();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      report_failure($sformatf("Timeout, the run did not finish in %0d cycles", timeout_cycles));
    end
  end

endmodule

`default_nettype wire

//--- src/axis_rx_dma.sv
`timescale 1ns/1ns
`default_nettype none

module axis_rx_dma (
  input  logic                     clk,
  input  logic                     rst,

  // AXI-Stream packet input
  input  dma_cfg_pkg::data_t       s_axis_tdata,
  input  dma_cfg_pkg::strb_t       s_axis_tkeep,
  input  logic                     s_axis_tvalid,
  output logic                     s_axis_tready,
  input  logic                     s_axis_tlast,
  // Slot that receives the packet
  input  dma_desc_pkg::slot_t      s_axis_tdest,
  // Port the packet arrived on
  input  dma_desc_pkg::port_t      s_axis_tuser,

  // Packet memory write port
  output logic                     mem_wr_en,
  output dma_cfg_pkg::strb_t       mem_wr_strb,
  output dma_cfg_pkg::addr_t       mem_wr_addr,
  output dma_cfg_pkg::data_t       mem_wr_data,
  output logic                     mem_wr_last,
  input  logic                     mem_wr_ready,

  // Finished receive descriptors
  output logic                     recv_desc_valid,
  input  logic                     recv_desc_ready,
  output dma_desc_pkg::recv_desc_t recv_desc
);

  import dma_desc_pkg::*;

  port_t pkt_port;

  rx_beat_if beat ();

  ////////////////////////////////////////////////////////////
  // Capture, realign and descriptor stages
  ////////////////////////////////////////////////////////////

  rx_capture u_rx_capture (
    .clk    (clk),
    .rst    (rst),
    .tdata  (s_axis_tdata),
    .tkeep  (s_axis_tkeep),
    .tvalid (s_axis_tvalid),
    .tready (s_axis_tready),
    .tlast  (s_axis_tlast),
    .tdest  (s_axis_tdest),
    .tuser  (s_axis_tuser),
    .beat   (beat.capture),
    .port   (pkt_port)
  );

  rx_realign u_rx_realign (
    .clk          (clk),
    .rst          (rst),
    .beat         (beat.realign),
    .mem_wr_en    (mem_wr_en),
    .mem_wr_strb  (mem_wr_strb),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .mem_wr_last  (mem_wr_last),
    .mem_wr_ready (mem_wr_ready)
  );

  // Descriptor stage watches the memory writes and the latched metadata
  rx_desc_build u_rx_desc_build (
    .clk             (clk),
    .rst             (rst),
    .mem_wr_en       (mem_wr_en),
    .mem_wr_strb     (mem_wr_strb),
    .mem_wr_last     (mem_wr_last),
    .mem_wr_ready    (mem_wr_ready),
    .start_addr      (beat.start_addr),
    .port            (pkt_port),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_ready (recv_desc_ready),
    .recv_desc       (recv_desc)
  );

endmodule

`default_nettype wire

//--- src/desc_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module desc_fifo #(
  parameter int depth = dma_desc_pkg::recv_desc_depth
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     push,
  input  dma_desc_pkg::recv_desc_t din,
  output logic                     full,
  output logic                     dout_valid,
  output dma_desc_pkg::recv_desc_t dout,
  input  logic                     pop_ready
);

  import dma_desc_pkg::*;

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  recv_desc_t       mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             pop;

  assign full       = (count == cnt_w'(depth));
  assign dout_valid = (count != '0);
  // Head entry is shown directly and holds until it is popped
  assign dout       = mem[rd_ptr];
  assign pop        = dout_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // The receive path never waits for descriptor space
  a_no_overflow : assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("desc_fifo received a descriptor while full");

endmodule

`default_nettype wire

//--- src/rx_path/rx_capture.sv
`timescale 1ns/1ns
`default_nettype none

module rx_capture (
  input  logic                clk,
  input  logic                rst,
  input  dma_cfg_pkg::data_t  tdata,
  input  dma_cfg_pkg::strb_t  tkeep,
  input  logic                tvalid,
  output logic                tready,
  input  logic                tlast,
  input  dma_desc_pkg::slot_t tdest,
  input  dma_desc_pkg::port_t tuser,
  rx_beat_if.capture          beat,
  output dma_desc_pkg::port_t port
);

  import dma_cfg_pkg::*;
  import dma_desc_pkg::*;

  logic   accept;
  logic   first_accept;
  logic   in_pkt;
  addr_t  new_addr;
  shift_t new_shift;
  shift_t cur_shift;
  logic   left_now;
  logic   strb_left;

  ////////////////////////////////////////////////////////////
  // Packet start detection and metadata
  ////////////////////////////////////////////////////////////

  assign accept       = tvalid && tready;
  // A beat is the head of a packet when the previous one closed with tlast
  assign first_accept = accept && !in_pkt;

  // Slot number in the high byte, fixed start offset in the low byte
  assign new_addr  = {tdest, lead_zero_bits'(slot_start_offset)};
  // Output lanes that the first beat fills in the first memory word
  assign new_shift = shift_t'(strb_w) - shift_t'(new_addr[mask_bits-1:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt <= 1'b0;
    end else if (accept) begin
      in_pkt <= !tlast;
    end
  end

  always_ff @(posedge clk) begin
    if (first_accept) begin
      beat.start_addr <= new_addr;
      beat.shift      <= new_shift;
      port            <= tuser;
    end
  end

  // Stays set until the first word of the packet is taken by memory
  always_ff @(posedge clk) begin
    if (rst) begin
      beat.first <= 1'b0;
    end else if (first_accept) begin
      beat.first <= 1'b1;
    end else if (beat.advance) begin
      beat.first <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 1 register
  ////////////////////////////////////////////////////////////

  // The head beat uses its own fresh shift, later beats the latched one
  assign cur_shift = first_accept ? new_shift : beat.shift;
  // Bytes above the shift belong to the following memory word
  assign left_now  = |(tkeep >> cur_shift);

  always_ff @(posedge clk) begin
    if (accept) begin
      beat.data <= tdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat.strb <= '0;
      beat.last <= 1'b0;
      strb_left <= 1'b0;
    end else if (beat.flush) begin
      // The last beat went out in its first word, only stage 2 bytes remain
      beat.strb <= '0;
      beat.last <= 1'b0;
      strb_left <= 1'b0;
    end else if (accept) begin
      beat.strb <= tkeep;
      beat.last <= tlast;
      strb_left <= left_now;
    end
  end

  // A final beat with leftover bytes needs one extra write
  assign beat.spill = beat.last && strb_left;
  assign beat.take  = accept;

  // Input waits while memory stalls or while the spill word is pending
  assign tready = beat.ready && !beat.spill;

endmodule

`default_nettype wire

//--- src/rx_path/rx_desc_build.sv
`timescale 1ns/1ns
`default_nettype none

module rx_desc_build (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     mem_wr_en,
  input  dma_cfg_pkg::strb_t       mem_wr_strb,
  input  logic                     mem_wr_last,
  input  logic                     mem_wr_ready,
  input  dma_cfg_pkg::addr_t       start_addr,
  input  dma_desc_pkg::port_t      port,
  output logic                     recv_desc_valid,
  input  logic                     recv_desc_ready,
  output dma_desc_pkg::recv_desc_t recv_desc
);

  import dma_cfg_pkg::*;
  import dma_desc_pkg::*;

  localparam int cnt_w = mask_bits + 1;

  logic             wr_fire;
  logic [cnt_w-1:0] one_count;
  len_t             len_q;
  len_t             next_len;
  logic             push;
  recv_desc_t       desc_in;

  ////////////////////////////////////////////////////////////
  // Byte count of the packet being written
  ////////////////////////////////////////////////////////////

  assign wr_fire = mem_wr_en && mem_wr_ready;

  // Number of bytes enabled in the current memory word
  always_comb begin
    one_count = '0;
    for (int i = 0; i < strb_w; i++) begin
      one_count = one_count + cnt_w'(mem_wr_strb[i]);
    end
  end

  assign next_len = len_q + len_t'(one_count);

  // Cleared after the closing write so the next packet counts from zero
  always_ff @(posedge clk) begin
    if (rst) begin
      len_q <= '0;
    end else if (wr_fire) begin
      len_q <= mem_wr_last ? '0 : next_len;
    end
  end

  ////////////////////////////////////////////////////////////
  // Descriptor assembly
  ////////////////////////////////////////////////////////////

  assign push = wr_fire && mem_wr_last;

  always_comb begin
    desc_in           = '0;
    desc_in.base_addr = start_addr;
    desc_in.port      = desc_port_w'(port);
    // Slot number is the address field above the in-slot offset
    desc_in.slot      = start_addr[addr_w-1:lead_zero_bits];
    desc_in.len       = next_len;
  end

  desc_fifo #(
    .depth (recv_desc_depth)
  ) u_desc_fifo (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .din        (desc_in),
    .full       (),
    .dout_valid (recv_desc_valid),
    .dout       (recv_desc),
    .pop_ready  (recv_desc_ready)
  );

endmodule

`default_nettype wire

//--- src/rx_path/rx_realign.sv
`timescale 1ns/1ns
`default_nettype none

module rx_realign (
  input  logic               clk,
  input  logic               rst,
  rx_beat_if.realign         beat,
  output logic               mem_wr_en,
  output dma_cfg_pkg::strb_t mem_wr_strb,
  output dma_cfg_pkg::addr_t mem_wr_addr,
  output dma_cfg_pkg::data_t mem_wr_data,
  output logic               mem_wr_last,
  input  logic               mem_wr_ready
);

  import dma_cfg_pkg::*;

  data_t               data_2;
  strb_t               strb_2;
  logic                spill_r;
  addr_t               next_addr;
  addr_t               aligned_addr;
  logic [2*data_w-1:0] data_pair;
  logic [2*strb_w-1:0] strb_pair;

  ////////////////////////////////////////////////////////////
  // Handshake back to the capture stage
  ////////////////////////////////////////////////////////////

  assign beat.ready   = mem_wr_ready;
  assign beat.advance = mem_wr_en && mem_wr_ready;
  // Accepting the word of a spilling beat empties stage 1
  assign beat.flush   = beat.advance && beat.spill;

  // Raised one cycle after a beat enters stage 1
  // Held through a stall, and held once more for the spill word
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr_en <= 1'b0;
    end else begin
      mem_wr_en <= beat.take || (mem_wr_en && !mem_wr_ready) || beat.flush;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2 and the spill marker
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (beat.advance) begin
      data_2 <= beat.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      strb_2 <= '0;
    end else if (mem_wr_last && mem_wr_ready) begin
      // Nothing of the finished packet may leak into the next one
      strb_2 <= '0;
    end else if (beat.advance) begin
      strb_2 <= beat.strb;
    end
  end

  // Set during the extra word that carries the spilled tail bytes
  always_ff @(posedge clk) begin
    if (rst) begin
      spill_r <= 1'b0;
    end else if (beat.advance) begin
      spill_r <= beat.spill;
    end
  end

  ////////////////////////////////////////////////////////////
  // Word assembly and addressing
  ////////////////////////////////////////////////////////////

  // Older beat in the low half, newer beat in the high half
  assign data_pair   = {beat.data, data_2} >> {beat.shift, 3'b000};
  assign strb_pair   = {beat.strb, strb_2} >> beat.shift;
  assign mem_wr_data = data_pair[data_w-1:0];
  assign mem_wr_strb = strb_pair[strb_w-1:0];

  assign aligned_addr = {beat.start_addr[addr_w-1:mask_bits], {mask_bits{1'b0}}};

  always_ff @(posedge clk) begin
    if (beat.advance) begin
      next_addr <= mem_wr_addr + addr_t'(strb_w);
    end
  end

  assign mem_wr_addr = beat.first ? aligned_addr : next_addr;

  // The spill word closes the packet when present, else the last beat's word
  assign mem_wr_last = mem_wr_en && ((beat.last && !beat.spill) || spill_r);

  // A stalled write must keep pointing at the same word
  property p_addr_hold;
    @(posedge clk) disable iff (rst)
      (mem_wr_en && !mem_wr_ready) |=> $stable(mem_wr_addr);
  endproperty

  a_addr_hold : assert property (p_addr_hold)
    else $error("rx_realign write address moved while the memory stalled");

endmodule

`default_nettype wire

//--- verilog.f
common/dma_cfg_pkg.sv
common/dma_desc_pkg.sv
common/rx_beat_if.sv
src/desc_fifo.sv
src/rx_path/rx_capture.sv
src/rx_path/rx_realign.sv
src/rx_path/rx_desc_build.sv
src/axis_rx_dma.sv
sim/tb_axis_rx_dma.sv
